//--- logic/cfu_config.svh
/*
 * matmul accelerator configuration
 * buffer sizes, array geometry and drain length
 */
`ifndef CFU_CONFIG_SVH
`define CFU_CONFIG_SVH

// buffer address widths (1024 entries each)
`define CFU_A_ADDR_BITS 10
`define CFU_B_ADDR_BITS 10

// K operand width
`define CFU_K_BITS 10

// lanes in the row, also bytes per weight word
`define CFU_LANES 4
`define CFU_ACC_BITS 32

// cycles past the last issued address until the east lane settles
`define CFU_DRAIN 5

`endif

//--- logic/cfu_pkg.sv
/*
 * matmul accelerator types
 * command opcodes, weight word views, array feed and result row
 */
`include "cfu_config.svh"

package cfu_pkg;

  // funct7 field of the command
  typedef enum logic [6:0] {
    op_write_a = 7'd0,
    op_write_b = 7'd1,
    op_compute = 7'd2,
    op_read    = 7'd3
  } cfu_op_e;

  // one weight word, either as written by the cpu or split per lane
  // lane 0 sits in the most significant byte
  typedef union packed {
    logic [`CFU_LANES*8-1:0]         raw;
    logic [0:`CFU_LANES-1][7:0]      lanes;
  } weight_word_u;

  // one cycle of input for the row
  // north bytes already carry the per-lane skew
  typedef struct packed {
    logic [7:0]                  west;
    logic [0:`CFU_LANES-1][7:0]  north;
  } row_feed_t;

  // lane results, lane 0 in the top word
  typedef logic signed [0:`CFU_LANES-1][`CFU_ACC_BITS-1:0] acc_row_t;

endpackage

//--- logic/mac_pe.sv
/*
 * mac cell
 * signed 8x8 multiply-accumulate with a registered eastward pass
 */
`include "cfu_config.svh"

module mac_pe (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            clear,
  input  logic [7:0]                      west,
  input  logic [7:0]                      north,
  output logic [7:0]                      east,
  output logic signed [`CFU_ACC_BITS-1:0] acc
);

  logic signed [15:0] product;

  assign product = 16'($signed(west)) * 16'($signed(north));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc  <= '0;
      east <= '0;
    end else begin
      east <= west;
      // clear wins so a new compute starts from zero
      if (clear) begin
        acc <= '0;
      end else begin
        // product sign-extended to the accumulator width
        acc <= acc + {{(`CFU_ACC_BITS-16){product[15]}}, product};
      end
    end
  end

endmodule

//--- logic/systolic_row.sv
/*
 * one-row systolic array
 * activations ripple west to east, each lane has its own weight byte
 */
`include "cfu_config.svh"

module systolic_row (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               clear,
  input  cfu_pkg::row_feed_t feed,
  output cfu_pkg::acc_row_t  result
);

  // west input of every lane, lane 0 straight from the feed
  logic [7:0]                     west_in [`CFU_LANES+1];
  logic signed [`CFU_ACC_BITS-1:0] lane_acc [`CFU_LANES];

  assign west_in[0] = feed.west;

  for (genvar i = 0; i < `CFU_LANES; i++) begin : g_pe
    mac_pe u_pe (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (clear),
      .west  (west_in[i]),
      .north (feed.north[i]),
      .east  (west_in[i+1]),
      .acc   (lane_acc[i])
    );
  end

  always_comb begin
    for (int i = 0; i < `CFU_LANES; i++) begin
      result[i] = lane_acc[i];
    end
  end

endmodule

//--- logic/operand_buffer.sv
/*
 * operand buffer
 * single-port memory with a registered read, writes win over reads
 */
module operand_buffer #(
  parameter int DATA_BITS = 8,
  parameter int ADDR_BITS = 10
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 we,
  input  logic [ADDR_BITS-1:0] index,
  input  logic [DATA_BITS-1:0] wdata,
  output logic [DATA_BITS-1:0] rdata
);

  localparam int DEPTH = 1 << ADDR_BITS;

  logic [DATA_BITS-1:0] mem [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (we) begin
      mem[index] <= wdata;
    end else begin
      // data shows up one cycle after the index
      rdata <= mem[index];
    end
  end

endmodule

//--- logic/matmul_sequencer.sv
/*
 * matmul sequencer
 * issues K buffer addresses, gates the returned data and skews the weight lanes
 */
`include "cfu_config.svh"

module matmul_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [`CFU_K_BITS-1:0]  k,
  input  logic [7:0]              act_feed,
  input  cfu_pkg::weight_word_u   wgt_feed,
  output logic [`CFU_K_BITS-1:0]  stream_addr,
  output logic                    done,
  output cfu_pkg::row_feed_t      feed
);

  localparam logic [`CFU_K_BITS:0] DRAIN_CNT = `CFU_DRAIN;

  logic                    running;
  logic [`CFU_K_BITS-1:0]  k_q;
  logic [`CFU_K_BITS-1:0]  addr;
  logic [`CFU_K_BITS:0]    cycle_cnt;
  logic                    issue;
  logic                    data_v;
  logic [7:0]              act_g;
  cfu_pkg::weight_word_u   wgt_g;
  logic [7:0]              lane_in [`CFU_LANES];

  assign issue       = running && (addr < k_q);
  assign done        = running && (cycle_cnt == {1'b0, k_q} + DRAIN_CNT);
  assign stream_addr = addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running   <= 1'b0;
      k_q       <= '0;
      addr      <= '0;
      cycle_cnt <= '0;
      data_v    <= 1'b0;
    end else begin
      // valid follows the address by the buffer read latency
      data_v <= issue;
      if (start) begin
        running   <= 1'b1;
        k_q       <= k;
        addr      <= '0;
        cycle_cnt <= 1;
      end else if (running) begin
        cycle_cnt <= cycle_cnt + 1'b1;
        if (issue) begin
          addr <= addr + 1'b1;
        end
        if (done) begin
          running <= 1'b0;
        end
      end
    end
  end

  // zero feed outside the stream keeps the accumulators still
  assign act_g = data_v ? act_feed : '0;
  assign wgt_g = data_v ? wgt_feed : '0;

  assign lane_in[0] = wgt_g.lanes[0];

  // lane j waits j cycles for its activation to travel east
  for (genvar j = 1; j < `CFU_LANES; j++) begin : g_skew
    logic [7:0] taps [j];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int d = 0; d < j; d++) begin
          taps[d] <= '0;
        end
      end else begin
        taps[0] <= wgt_g.lanes[j];
        for (int d = 1; d < j; d++) begin
          taps[d] <= taps[d-1];
        end
      end
    end

    assign lane_in[j] = taps[j-1];
  end

  always_comb begin
    feed.west = act_g;
    for (int j = 0; j < `CFU_LANES; j++) begin
      feed.north[j] = lane_in[j];
    end
  end

endmodule

//--- logic/cfu_command_ctrl.sv
/*
 * command controller
 * decodes funct7, latches operands, steers buffer ports and strobes the response
 */
`include "cfu_config.svh"

module cfu_command_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  input  logic [9:0]                   cmd_function_id,
  input  logic [31:0]                  cmd_inputs_0,
  input  logic [31:0]                  cmd_inputs_1,
  output logic                         rsp_valid,
  input  logic                         rsp_ready,
  output logic [31:0]                  rsp_output,
  output logic                         act_we,
  output logic [`CFU_A_ADDR_BITS-1:0]  act_index,
  output logic [7:0]                   act_wdata,
  input  logic [7:0]                   act_rdata,
  output logic                         wgt_we,
  output logic [`CFU_B_ADDR_BITS-1:0]  wgt_index,
  output cfu_pkg::weight_word_u        wgt_wdata,
  input  cfu_pkg::weight_word_u        wgt_rdata,
  input  logic [`CFU_K_BITS-1:0]       stream_addr,
  output logic                         start,
  output logic [`CFU_K_BITS-1:0]       k,
  input  logic                         done,
  output logic [7:0]                   act_feed,
  output cfu_pkg::weight_word_u        wgt_feed,
  input  cfu_pkg::acc_row_t            result
);

  localparam int LANE_BITS = $clog2(`CFU_LANES);

  typedef enum logic [2:0] {
    st_idle,
    st_write_a,
    st_write_b,
    st_read,
    st_prepare,
    st_compute,
    st_finish
  } state_e;

  state_e           state;
  state_e           next_state;
  cfu_pkg::cfu_op_e funct7;
  logic             accept;
  logic [31:0]      op0_q;
  logic [31:0]      op1_q;
  logic [LANE_BITS-1:0] lane_sel;

  assign funct7 = cfu_pkg::cfu_op_e'(cmd_function_id[9:3]);
  assign accept = (state == st_idle) && cmd_valid;

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (cmd_valid) begin
          case (funct7)
            cfu_pkg::op_write_a: next_state = st_write_a;
            cfu_pkg::op_write_b: next_state = st_write_b;
            cfu_pkg::op_compute: next_state = st_prepare;
            cfu_pkg::op_read:    next_state = st_read;
            // unknown opcode is dropped without a response
            default:             next_state = st_idle;
          endcase
        end
      end
      st_write_a, st_write_b, st_read: next_state = st_finish;
      st_prepare: next_state = st_compute;
      st_compute: begin
        if (done) begin
          next_state = st_finish;
        end
      end
      st_finish: next_state = st_idle;
      default:   next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      op0_q <= '0;
      op1_q <= '0;
    end else begin
      state <= next_state;
      if (accept) begin
        op0_q <= cmd_inputs_0;
        op1_q <= cmd_inputs_1;
      end
    end
  end

  // buffer ports, stream address owns the index while computing
  assign act_we     = (state == st_write_a);
  assign wgt_we     = (state == st_write_b);
  assign act_index  = (state == st_compute) ? stream_addr[`CFU_A_ADDR_BITS-1:0]
                                            : op0_q[`CFU_A_ADDR_BITS-1:0];
  assign wgt_index  = (state == st_compute) ? stream_addr[`CFU_B_ADDR_BITS-1:0]
                                            : op0_q[`CFU_B_ADDR_BITS-1:0];
  assign act_wdata  = op1_q[31:24];
  assign wgt_wdata.raw = op1_q;

  // sequencer handoff
  assign start    = (state == st_prepare);
  assign k        = op0_q[`CFU_K_BITS-1:0];
  assign act_feed = act_rdata;
  assign wgt_feed = wgt_rdata;

  // response, no hold under back-pressure
  assign cmd_ready  = rsp_ready;
  assign rsp_valid  = (state == st_finish);
  assign lane_sel   = op1_q[LANE_BITS-1:0];
  assign rsp_output = result[lane_sel];

endmodule

//--- logic/cfu_top.sv
/*
 * matmul accelerator top
 * command controller, operand buffers, sequencer and mac row
 */
`include "cfu_config.svh"

module cfu_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_output
);

  logic                          act_we;
  logic [`CFU_A_ADDR_BITS-1:0]   act_index;
  logic [7:0]                    act_wdata;
  logic [7:0]                    act_rdata;
  logic                          wgt_we;
  logic [`CFU_B_ADDR_BITS-1:0]   wgt_index;
  cfu_pkg::weight_word_u         wgt_wdata;
  cfu_pkg::weight_word_u         wgt_rdata;

  logic                          start;
  logic                          done;
  logic [`CFU_K_BITS-1:0]        k;
  logic [`CFU_K_BITS-1:0]        stream_addr;
  logic [7:0]                    act_feed;
  cfu_pkg::weight_word_u         wgt_feed;
  cfu_pkg::row_feed_t            feed;
  cfu_pkg::acc_row_t             result;

  cfu_command_ctrl u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_output      (rsp_output),
    .act_we          (act_we),
    .act_index       (act_index),
    .act_wdata       (act_wdata),
    .act_rdata       (act_rdata),
    .wgt_we          (wgt_we),
    .wgt_index       (wgt_index),
    .wgt_wdata       (wgt_wdata),
    .wgt_rdata       (wgt_rdata),
    .stream_addr     (stream_addr),
    .start           (start),
    .k               (k),
    .done            (done),
    .act_feed        (act_feed),
    .wgt_feed        (wgt_feed),
    .result          (result)
  );

  // activation bytes
  operand_buffer #(
    .DATA_BITS (8),
    .ADDR_BITS (`CFU_A_ADDR_BITS)
  ) act_buf (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (act_we),
    .index (act_index),
    .wdata (act_wdata),
    .rdata (act_rdata)
  );

  // packed weight words
  operand_buffer #(
    .DATA_BITS ($bits(cfu_pkg::weight_word_u)),
    .ADDR_BITS (`CFU_B_ADDR_BITS)
  ) wgt_buf (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (wgt_we),
    .index (wgt_index),
    .wdata (wgt_wdata),
    .rdata (wgt_rdata)
  );

  matmul_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .k           (k),
    .act_feed    (act_feed),
    .wgt_feed    (wgt_feed),
    .stream_addr (stream_addr),
    .done        (done),
    .feed        (feed)
  );

  // start doubles as the accumulator clear
  systolic_row u_row (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (start),
    .feed   (feed),
    .result (result)
  );

endmodule

//--- testbench/cfu_props.sv
/*
 * protocol checks for the matmul accelerator
 * bound to the top level, sees its ports only
 */
module cfu_props (
  input logic       clk,
  input logic       rst_n,
  input logic       cmd_valid,
  input logic       cmd_ready,
  input logic [9:0] cmd_function_id,
  input logic       rsp_valid,
  input logic       rsp_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [6:0] funct7;
  logic       short_cmd;
  logic       reset_bad = 1'b0;
  logic       release_bad = 1'b0;
  logic       latency_bad = 1'b0;
  logic       pulse_bad = 1'b0;
  logic       ready_bad = 1'b0;
  logic       unknown_bad = 1'b0;
  logic       failed;

  assign funct7 = cmd_function_id[9:3];

  // write A, write B and read all answer after a single operation cycle
  assign short_cmd = cmd_valid && (funct7 == cfu_pkg::op_write_a ||
                                   funct7 == cfu_pkg::op_write_b ||
                                   funct7 == cfu_pkg::op_read);

  assign failed = reset_bad | release_bad | latency_bad | pulse_bad | ready_bad | unknown_bad;

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !rsp_valid)
    else begin
      $error("rsp_valid high while reset is held");
      reset_bad = 1'b1;
    end

  // first edge after release
  release_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !rsp_valid)
    else begin
      $error("rsp_valid high right after reset release");
      release_bad = 1'b1;
    end

  short_latency: assert property (@(posedge clk) disable iff (!rst_n)
      short_cmd |-> !rsp_valid ##1 !rsp_valid ##1 rsp_valid)
    else begin
      $error("response strobe not two edges after the command");
      latency_bad = 1'b1;
    end

  single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |=> !rsp_valid)
    else begin
      $error("rsp_valid held longer than one cycle");
      pulse_bad = 1'b1;
    end

  ready_mirror: assert property (@(posedge clk) cmd_ready == rsp_ready)
    else begin
      $error("cmd_ready differs from rsp_ready");
      ready_bad = 1'b1;
    end

  unknown_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && (funct7 > 7'd3) |-> ##1 !rsp_valid ##1 !rsp_valid ##1 !rsp_valid)
    else begin
      $error("unknown opcode produced a response");
      unknown_bad = 1'b1;
    end

endmodule

//--- testbench/cfu_tb.sv
/*
 * testbench for the matmul accelerator
 * drives cpu commands and checks lane results against a software model
 */
module cfu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 16;
  localparam int LANES = 4;
  localparam int RSP_TIMEOUT = 100;
  localparam int QUIET_WINDOW = 20;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_function_id;
  logic [31:0] cmd_inputs_0;
  logic [31:0] cmd_inputs_1;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_output;

  logic [15:0]       lfsr_state;
  logic signed [7:0] a_mem [DEPTH];
  logic [31:0]       b_mem [DEPTH];

  cfu_top UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_output      (rsp_output)
  );

  bind cfu_top cfu_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping after the first failure");
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // lane j sums A[k] times byte j of B[k] with byte 0 at the top
  function automatic logic signed [31:0] lane_model(input int lane, input int k_len);
    logic signed [31:0] sum;
    logic signed [7:0]  w;
    sum = '0;
    for (int i = 0; i < k_len; i++) begin
      w = b_mem[i][31-8*lane -: 8];
      sum = sum + 32'(a_mem[i]) * 32'(w);
    end
    return sum;
  endfunction

  task automatic drive_command(input logic [6:0] op, input logic [31:0] in0,
                               input logic [31:0] in1);
    @(posedge clk);
    #5;
    cmd_valid       = 1'b1;
    cmd_function_id = {op, 3'b000};
    cmd_inputs_0    = in0;
    cmd_inputs_1    = in1;
    @(posedge clk);
    #5;
    cmd_valid = 1'b0;
  endtask

  task automatic send_command(input logic [6:0] op, input logic [31:0] in0,
                              input logic [31:0] in1, output logic [31:0] data);
    bit seen;
    seen = 1'b0;
    data = '0;
    drive_command(op, in0, in1);
    // strobe is stable between two rising edges
    for (int n = 0; n < RSP_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      if (rsp_valid) begin
        seen = 1'b1;
        data = rsp_output;
      end
    end
    if (!seen) begin
      abort_run($sformatf("no response to opcode %0d within %0d cycles", op, RSP_TIMEOUT));
    end
  endtask

  task automatic expect_silence(input logic [6:0] op);
    drive_command(op, 32'd0, 32'd0);
    for (int n = 0; n < QUIET_WINDOW; n++) begin
      @(negedge clk);
      if (rsp_valid) begin
        abort_run($sformatf("response strobe seen for unknown opcode %0d", op));
      end
    end
  endtask

  task automatic check_lane(input int lane, input logic [31:0] expected);
    logic [31:0] data;
    send_command(cfu_pkg::op_read, 32'd0, 32'(lane), data);
    assert (data === expected) else begin
      $display("** Error at %0d ns: rsp_output lane %0d expected %0d, got %0d",
               $time, lane, $signed(expected), $signed(data));
      abort_run("read data does not match the model");
    end
  endtask

  task automatic check_all_lanes(input int k_len);
    for (int lane = 0; lane < LANES; lane++) begin
      check_lane(lane, lane_model(lane, k_len));
    end
  endtask

  task automatic run_compute(input int k_len);
    logic [31:0] data;
    send_command(cfu_pkg::op_compute, 32'(k_len), 32'd0, data);
  endtask

  task automatic fill_buffers();
    logic [31:0] bits;
    logic [31:0] data;
    for (int i = 0; i < DEPTH; i++) begin
      random_bits(8, bits);
      a_mem[i] = bits[7:0];
      if (i == 0) begin
        // one activation is always negative
        a_mem[i] = bits[7:0] | 8'h80;
      end
      random_bits(32, bits);
      b_mem[i] = bits;
      send_command(cfu_pkg::op_write_a, 32'(i), {a_mem[i], 24'h0}, data);
      send_command(cfu_pkg::op_write_b, 32'(i), b_mem[i], data);
    end
  endtask

  always @(negedge clk) begin
    if (UUT.u_props.failed) begin
      abort_run("a protocol assertion on the cfu ports failed");
    end
  end

  initial begin
    int          k1;
    int          k2;
    logic [31:0] bits;
    clk             = 1'b0;
    rst_n           = 1'b0;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    rsp_ready       = 1'b1;
    lfsr_state      = 16'd30;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // accumulators leave reset at zero
    for (int lane = 0; lane < LANES; lane++) begin
      check_lane(lane, 32'd0);
    end

    fill_buffers();
    random_bits(4, bits);
    k1 = int'(bits[3:0]) + 1;
    run_compute(k1);
    check_all_lanes(k1);

    // empty stream only clears
    run_compute(0);
    for (int lane = 0; lane < LANES; lane++) begin
      check_lane(lane, 32'd0);
    end

    random_bits(4, bits);
    k2 = int'(bits[3:0]) + 1;
    if (k2 == k1) begin
      k2 = (k1 % DEPTH) + 1;
    end
    run_compute(k2);
    check_all_lanes(k2);

    // results survive a dropped command
    expect_silence(7'd9);
    check_all_lanes(k2);

    if (UUT.u_props.failed) begin
      abort_run("a protocol assertion on the cfu ports failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- filelist.f
+incdir+logic
logic/cfu_pkg.sv
logic/mac_pe.sv
logic/systolic_row.sv
logic/operand_buffer.sv
logic/matmul_sequencer.sv
logic/cfu_command_ctrl.sv
logic/cfu_top.sv
testbench/cfu_props.sv
testbench/cfu_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := cfu_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
SIM_FLAGS := +verilator+error+limit+100
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
